// ==== freeListCfgPkg.sv ====
// Sizing constants for the four-wide rename free list and its pointers.
package freeListCfgPkg;

  ////////////////////////////////////////////////////////////
  // Machine width
  ////////////////////////////////////////////////////////////

  localparam int dispatchWidth = 4;                    // Rename and commit lanes.

  ////////////////////////////////////////////////////////////
  // Register files
  ////////////////////////////////////////////////////////////

  localparam int physRegs = 64;                        // Physical registers.
  localparam int archRegs = 32;                        // Architectural registers.

  localparam int tagBits = $clog2(physRegs);           // Physical tag width.

  ////////////////////////////////////////////////////////////
  // Free list sizing
  ////////////////////////////////////////////////////////////

  // Architectural state is mapped at reset, the remainder starts free.
  localparam int defaultListDepth = physRegs - archRegs;

  localparam int ptrBits = $clog2(defaultListDepth);   // Head and tail width.

endpackage

// ==== renameTypesPkg.sv ====
// Packed types exchanged between rename decode, the free list and commit release.
package renameTypesPkg;

  import freeListCfgPkg::*;

  ////////////////////////////////////////////////////////////
  // Scalar types
  ////////////////////////////////////////////////////////////

  typedef logic [tagBits-1:0]                 physTagT;    // Physical register tag.
  typedef logic [ptrBits-1:0]                 listPtrT;    // Head, tail or checkpoint.
  typedef logic [dispatchWidth-1:0]           laneMaskT;   // One bit per lane.
  typedef logic [$clog2(dispatchWidth+1)-1:0] laneCountT;  // Zero up to four.

  ////////////////////////////////////////////////////////////
  // Rename side
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    laneMaskT                       valid;   // All set or all clear.
    physTagT [dispatchWidth-1:0]    tag;
  } freeTagsT;

  typedef struct packed {
    laneCountT popCount;                     // Zero when advance is low.
    logic      advance;
  } allocReqT;

  ////////////////////////////////////////////////////////////
  // Commit side
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    laneMaskT                       valid;   // Sparse, any pattern.
    physTagT [dispatchWidth-1:0]    tag;
  } commitRelT;

  typedef struct packed {
    laneMaskT                       en;      // Dense from lane 0.
    physTagT [dispatchWidth-1:0]    tag;
    laneCountT                      count;
  } pushLanesT;

  typedef struct packed {
    logic    fullRecover;
    logic    branchRecover;
    listPtrT checkpoint;                     // Head saved at the branch.
  } recoverT;

endpackage

// ==== renameDecode.sv ====
// Rename decode: turns lane requests, stall and availability into a pop count.
`timescale 1ns/1ns

module renameDecode (
  input  renameTypesPkg::laneMaskT reqMask_i,
  input  logic                     stall_i,
  input  logic                     freeAvail_i,
  output renameTypesPkg::allocReqT alloc_o
);

  import freeListCfgPkg::*;
  import renameTypesPkg::*;

  laneCountT reqCount;
  logic      advance;

  ////////////////////////////////////////////////////////////
  // Request count
  ////////////////////////////////////////////////////////////

  // Lanes need not be contiguous; every set bit takes one tag.
  always_comb begin
    reqCount = '0;
    for (int k = 0; k < dispatchWidth; k++) begin
      reqCount = reqCount + laneCountT'(reqMask_i[k]);
    end
  end

  ////////////////////////////////////////////////////////////
  // Advance qualification
  ////////////////////////////////////////////////////////////

  // The whole group moves or none of it does.
  assign advance = ~stall_i & freeAvail_i;

  always_comb begin
    alloc_o.advance  = advance;
    alloc_o.popCount = '0;                     // Blocked group pops nothing.
    if (advance) begin
      alloc_o.popCount = reqCount;
    end
  end

endmodule

// ==== commitRelease.sv ====
// Commit release: packs sparse committed tags into dense push lanes and counts them.
`timescale 1ns/1ns

module commitRelease (
  input  renameTypesPkg::commitRelT commit_i,
  output renameTypesPkg::pushLanesT push_o
);

  import freeListCfgPkg::*;
  import renameTypesPkg::*;

  localparam int laneIdxBits = $clog2(dispatchWidth);

  ////////////////////////////////////////////////////////////
  // Lane compaction
  ////////////////////////////////////////////////////////////

  // Lowest valid commit lane lands in push lane 0, the next in lane 1,
  // and so on, so the tail sees one contiguous run of writes.
  always_comb begin : compactLanes
    laneCountT fill;
    push_o = '0;
    fill   = '0;
    for (int k = 0; k < dispatchWidth; k++) begin
      if (commit_i.valid[k]) begin
        push_o.en[fill[laneIdxBits-1:0]]  = 1'b1;
        push_o.tag[fill[laneIdxBits-1:0]] = commit_i.tag[k];
        fill = fill + laneCountT'(1);          // Next free push lane.
      end
    end
    push_o.count = fill;                       // Tail advance.
  end

endmodule

// ==== freeListRam.sv ====
// Free list storage: four asynchronous reads, four synchronous writes, preloaded tags.
`timescale 1ns/1ns

module freeListRam #(
  parameter int listDepth = freeListCfgPkg::defaultListDepth
) (
  input  logic                                                 clk,
  input  logic                                                 reset,
  input  renameTypesPkg::listPtrT [freeListCfgPkg::dispatchWidth-1:0] readAddr_i,
  input  renameTypesPkg::pushLanesT                            push_i,
  input  renameTypesPkg::listPtrT [freeListCfgPkg::dispatchWidth-1:0] writeAddr_i,
  output renameTypesPkg::physTagT [freeListCfgPkg::dispatchWidth-1:0] readTag_o
);

  import freeListCfgPkg::*;
  import renameTypesPkg::*;

  physTagT mem [listDepth];

  ////////////////////////////////////////////////////////////
  // Write ports
  ////////////////////////////////////////////////////////////

  // Entries above the architectural tags are the initial free set.
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < listDepth; i++) begin
        mem[i] <= physTagT'(archRegs + i);
      end
    end else begin
      for (int k = 0; k < dispatchWidth; k++) begin
        if (push_i.en[k]) begin
          mem[writeAddr_i[k]] <= push_i.tag[k];  // Addresses never collide.
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Read ports
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int k = 0; k < dispatchWidth; k++) begin
      readTag_o[k] = mem[readAddr_i[k]];
    end
  end

endmodule

// ==== specFreeList.sv ====
// Speculative free list: head, tail and occupancy with full and branch recovery.
`timescale 1ns/1ns

module specFreeList #(
  parameter int listDepth = freeListCfgPkg::defaultListDepth
) (
  input  logic                      clk,
  input  logic                      reset,
  input  renameTypesPkg::allocReqT  alloc_i,
  input  renameTypesPkg::pushLanesT push_i,
  input  renameTypesPkg::recoverT   recover_i,
  output logic                      freeAvail_o,
  output renameTypesPkg::listPtrT   freeListHead_o,
  output renameTypesPkg::freeTagsT  freeTags_o,
  output logic                      freeListEmpty_o
);

  import freeListCfgPkg::*;
  import renameTypesPkg::*;

  localparam logic [ptrBits:0] depthCnt = (ptrBits + 1)'(listDepth);
  localparam logic [ptrBits:0] groupCnt = (ptrBits + 1)'(dispatchWidth);

  listPtrT                     head;
  listPtrT                     tail;
  logic [ptrBits:0]            count;         // Zero up to listDepth.
  listPtrT                     headNext;
  listPtrT                     tailNext;
  logic [ptrBits:0]            countHold;
  logic [ptrBits:0]            countAdv;
  logic [ptrBits:0]            countCp;
  logic                        freeAvail;
  listPtrT [dispatchWidth-1:0] readAddr;
  listPtrT [dispatchWidth-1:0] writeAddr;
  physTagT [dispatchWidth-1:0] readTag;

  // Modular add; one subtraction covers depths that are not powers of two.
  function automatic listPtrT wrapAdd(listPtrT ptr, laneCountT inc);
    logic [ptrBits:0] sum;
    sum = {1'b0, ptr} + (ptrBits + 1)'(inc);
    if (sum >= depthCnt) begin
      sum = sum - depthCnt;
    end
    return sum[ptrBits-1:0];
  endfunction

  ////////////////////////////////////////////////////////////
  // Port addressing
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int k = 0; k < dispatchWidth; k++) begin
      readAddr[k]  = wrapAdd(head, laneCountT'(k));
      writeAddr[k] = wrapAdd(tail, laneCountT'(k));
    end
  end

  freeListRam #(
    .listDepth(listDepth)
  ) i_freeListRam (
    .clk        (clk),
    .reset      (reset),
    .readAddr_i (readAddr),
    .push_i     (push_i),
    .writeAddr_i(writeAddr),
    .readTag_o  (readTag)
  );

  ////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////

  assign headNext  = wrapAdd(head, alloc_i.popCount);
  assign tailNext  = wrapAdd(tail, push_i.count);
  assign countHold = count + (ptrBits + 1)'(push_i.count);
  assign countAdv  = countHold - (ptrBits + 1)'(alloc_i.popCount);

  // Distance from checkpoint to the new tail; equal pointers mean full.
  always_comb begin
    if (tailNext > recover_i.checkpoint) begin
      countCp = {1'b0, tailNext} - {1'b0, recover_i.checkpoint};
    end else begin
      countCp = depthCnt - {1'b0, recover_i.checkpoint} + {1'b0, tailNext};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      head  <= '0;
      count <= depthCnt;
    end else if (recover_i.fullRecover) begin
      head  <= tail;                          // Every in-flight tag comes back.
      count <= depthCnt;
    end else if (recover_i.branchRecover) begin
      head  <= recover_i.checkpoint;
      count <= countCp;
    end else if (alloc_i.advance) begin
      head  <= headNext;
      count <= countAdv;
    end else begin
      count <= countHold;                     // Stalled or empty.
    end
  end

  // Releases land regardless of rename state.
  always_ff @(posedge clk) begin
    if (reset) begin
      tail <= '0;
    end else begin
      tail <= tailNext;
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  assign freeAvail       = (count >= groupCnt);
  assign freeAvail_o     = freeAvail;
  assign freeListEmpty_o = ~freeAvail;
  assign freeListHead_o  = head;

  always_comb begin
    freeTags_o = '0;                          // No partial groups.
    if (freeAvail) begin
      freeTags_o.valid = '1;
      freeTags_o.tag   = readTag;
    end
  end

endmodule

// ==== renameFreeListTop.sv ====
// Rename free list top: request decode, speculative free list and commit release.
`timescale 1ns/1ns

module renameFreeListTop #(
  parameter int listDepth = freeListCfgPkg::defaultListDepth
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      stall_i,
  input  renameTypesPkg::laneMaskT  reqMask_i,
  input  renameTypesPkg::commitRelT commit_i,
  input  renameTypesPkg::recoverT   recover_i,
  output renameTypesPkg::freeTagsT  freeTags_o,
  output renameTypesPkg::listPtrT   freeListHead_o,
  output logic                      freeListEmpty_o
);

  import renameTypesPkg::*;

  allocReqT  alloc;
  pushLanesT push;
  logic      freeAvail;

  ////////////////////////////////////////////////////////////
  // Rename side
  ////////////////////////////////////////////////////////////

  renameDecode i_renameDecode (
    .reqMask_i  (reqMask_i),
    .stall_i    (stall_i),
    .freeAvail_i(freeAvail),
    .alloc_o    (alloc)
  );

  ////////////////////////////////////////////////////////////
  // Commit side
  ////////////////////////////////////////////////////////////

  commitRelease i_commitRelease (
    .commit_i(commit_i),
    .push_o  (push)
  );

  ////////////////////////////////////////////////////////////
  // List state and storage
  ////////////////////////////////////////////////////////////

  specFreeList #(
    .listDepth(listDepth)
  ) i_specFreeList (
    .clk            (clk),
    .reset          (reset),
    .alloc_i        (alloc),
    .push_i         (push),
    .recover_i      (recover_i),
    .freeAvail_o    (freeAvail),
    .freeListHead_o (freeListHead_o),           // Checkpoint source.
    .freeTags_o     (freeTags_o),
    .freeListEmpty_o(freeListEmpty_o)
  );

endmodule

// ==== tbRenameFreeList.sv ====
// Testbench for the rename free list: file-driven cycles against a ring model, with a watchdog.
`timescale 1ns/1ns

module tbRenameFreeList;

  import freeListCfgPkg::*;
  import renameTypesPkg::*;

  localparam int listDepth = 32;
  localparam int maxLines  = 64;

  // One stimulus line; marker is 1 on every real line.
  typedef struct packed {
    logic [3:0] marker;
    laneMaskT   req;
    logic [3:0] stall;
    laneMaskT   commit;
    logic [3:0] recover;                       // 1 full, 2 branch.
    logic [3:0] save;                          // Take a checkpoint this cycle.
    logic [3:0] empty;
    logic [7:0] occupancy;
  } stimLineT;

  logic      clk;
  logic      reset;
  logic      stall;
  laneMaskT  reqMask;
  commitRelT commit;
  recoverT   recover;
  freeTagsT  freeTags;
  listPtrT   freeListHead;
  logic      freeListEmpty;

  logic [35:0] raw [maxLines];
  int          lineCount;
  int          seed;
  physTagT     ring [listDepth];               // Model of the list storage.
  int          head;
  int          tail;
  int          count;
  int          cpHead;
  physTagT     pool [$];                       // Allocated, not yet released.
  physTagT     snap [$];                       // Free queue seen at the checkpoint.
  physTagT     pushed [$];
  logic        checkSnap;

  renameFreeListTop #(
    .listDepth(listDepth)
  ) i_dut (
    .clk            (clk),
    .reset          (reset),
    .stall_i        (stall),
    .reqMask_i      (reqMask),
    .commit_i       (commit),
    .recover_i      (recover),
    .freeTags_o     (freeTags),
    .freeListHead_o (freeListHead),
    .freeListEmpty_o(freeListEmpty)
  );

  ////////////////////////////////////////////////////////////
  // Reporting and compare tasks
  ////////////////////////////////////////////////////////////

  task automatic reportMismatch(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    $display("CHECKS FAILED");
    $fatal(1, "first mismatch ends the run");
  endtask

  task automatic abortRun(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic checkFreeTags(input freeTagsT expTags, input freeTagsT gotTags, input string what);
    if (gotTags !== expTags) begin
      reportMismatch($sformatf("%s: free tags %h, expected %h", what, gotTags, expTags));
    end
  endtask

  task automatic checkHead(input listPtrT expHead, input listPtrT gotHead, input string what);
    if (gotHead !== expHead) begin
      reportMismatch($sformatf("%s: head %0d, expected %0d", what, gotHead, expHead));
    end
  endtask

  task automatic checkEmpty(input logic expEmpty, input logic gotEmpty, input string what);
    if (gotEmpty !== expEmpty) begin
      reportMismatch($sformatf("%s: empty flag %b, expected %b", what, gotEmpty, expEmpty));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic freeTagsT expectedTags();
    freeTagsT t;
    t = '0;
    if (count >= dispatchWidth) begin
      t.valid = '1;
      for (int k = 0; k < dispatchWidth; k++) begin
        t.tag[k] = ring[(head + k) % listDepth];
      end
    end
    return t;
  endfunction

  // Released tags come from the allocated pool, in lane order.
  task automatic driveLine(input stimLineT line);
    int pick;
    commit = '0;
    pushed.delete();
    reqMask = line.req;
    stall   = line.stall[0];
    for (int k = 0; k < dispatchWidth; k++) begin
      if (line.commit[k]) begin
        if (pool.size() == 0) begin
          abortRun("a commit lane is set but no allocated tag is left to release");
        end
        pick = $unsigned($random(seed)) % pool.size();
        commit.valid[k] = 1'b1;
        commit.tag[k]   = pool[pick];
        pushed.push_back(pool[pick]);
        pool.delete(pick);
      end
    end
    recover.fullRecover   = (line.recover == 4'd1);
    recover.branchRecover = (line.recover == 4'd2);
    recover.checkpoint    = listPtrT'(cpHead);
  endtask

  task automatic checkCycle(input stimLineT line, input int num);
    freeTagsT snapTags;
    string    where;
    where = $sformatf("line %0d", num);
    if (count != int'(line.occupancy)) begin
      reportMismatch($sformatf("%s: model occupancy %0d, file expects %0d",
                               where, count, line.occupancy));
    end
    checkFreeTags(expectedTags(), freeTags, where);
    checkHead(listPtrT'(head), freeListHead, where);
    checkEmpty(count < dispatchWidth, freeListEmpty, where);
    checkEmpty(line.empty[0], freeListEmpty, where);
    if (checkSnap && count >= dispatchWidth) begin
      snapTags       = '0;
      snapTags.valid = '1;
      for (int k = 0; k < dispatchWidth; k++) begin
        snapTags.tag[k] = snap[k];
      end
      checkFreeTags(snapTags, freeTags, {where, " after branch recovery"});
    end
    checkSnap = 1'b0;
  endtask

  task automatic updateModel(input stimLineT line);
    int pops;
    int oldTail;
    pops = 0;
    if (!line.stall[0] && count >= dispatchWidth) begin
      pops = $countones(line.req);
    end
    if (line.save[0]) begin
      cpHead = head;
      snap.delete();
      for (int i = 0; i < count; i++) begin
        snap.push_back(ring[(head + i) % listDepth]);
      end
    end
    oldTail = tail;
    foreach (pushed[i]) begin
      ring[tail] = pushed[i];
      tail = (tail + 1) % listDepth;
      snap.push_back(pushed[i]);
    end
    if (line.recover == 4'd1) begin
      head  = oldTail;                         // Every in-flight tag is free again.
      count = listDepth;
      pool.delete();
    end else if (line.recover == 4'd2) begin
      for (int p = cpHead; p != head; p = (p + 1) % listDepth) begin
        for (int i = pool.size() - 1; i >= 0; i--) begin
          if (pool[i] == ring[p]) begin
            pool.delete(i);
          end
        end
      end
      head  = cpHead;
      count = (tail - cpHead + listDepth) % listDepth;
      if (count == 0) begin
        count = listDepth;
      end
      checkSnap = 1'b1;
    end else begin
      for (int i = 0; i < pops; i++) begin
        pool.push_back(ring[head]);
        head = (head + 1) % listDepth;
      end
      count = count - pops + pushed.size();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Clock, watchdog and stimulus
  ////////////////////////////////////////////////////////////

  initial begin : clockGen
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  initial begin : watchdog
    wait (lineCount > 0);
    #((lineCount + 4) * 4 + 40);
    $display("watchdog: the run went past the time its stimulus needs");
    $display("CHECKS FAILED");
    $fatal(1, "timeout");
  end

  initial begin : stimulus
    reset     = 1'b1;
    stall     = 1'b0;
    reqMask   = '0;
    commit    = '0;
    recover   = '0;
    seed      = 32'h242a;
    checkSnap = 1'b0;
    cpHead    = 0;
    head      = 0;
    tail      = 0;
    count     = listDepth;
    lineCount = 0;
    for (int i = 0; i < listDepth; i++) begin
      ring[i] = physTagT'(archRegs + i);
    end
    $readmemh("freeListInput.txt", raw);
    while (lineCount < maxLines && raw[lineCount][35:32] == 4'h1) begin
      lineCount++;
    end
    if (lineCount == 0) begin
      abortRun("no stimulus lines could be read from freeListInput.txt");
    end
    repeat (2) @(posedge clk);
    #1 reset = 1'b0;
    for (int i = 0; i < lineCount; i++) begin
      driveLine(stimLineT'(raw[i]));
      #2;                                      // Outputs settled before the edge.
      checkCycle(stimLineT'(raw[i]), i + 1);
      updateModel(stimLineT'(raw[i]));
      @(posedge clk);
      #1;
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// ==== freeListInput.txt ====
// Columns: marker(1) reqMask stall commitMask recover(1 full, 2 branch) saveCheckpoint
// then expected empty flag and expected occupancy in hex; one line per clock cycle.
1_f_0_0_0_0_0_20
1_f_0_0_0_0_0_1c
1_a_0_0_0_0_0_18
1_f_1_5_0_0_0_16
1_5_1_0_0_0_0_18
1_f_0_0_0_1_0_18
1_f_0_0_0_0_0_14
1_7_0_0_0_0_0_10
1_0_0_0_2_0_0_0d
1_f_0_0_0_0_0_18
1_f_0_0_0_0_0_14
1_f_0_0_0_0_0_10
1_f_0_0_0_0_0_0c
1_f_0_0_0_0_0_08
1_3_0_0_0_0_0_04
1_f_0_0_0_0_1_02
1_f_0_1_0_0_1_02
1_f_0_1_0_0_1_03
1_f_0_e_0_0_0_04
1_1_0_0_0_0_1_03
1_0_0_f_1_0_1_03
1_f_0_0_0_0_0_20
1_0_0_0_0_0_0_1c

// ==== filelist.f ====
freeListCfgPkg.sv
renameTypesPkg.sv
renameDecode.sv
commitRelease.sv
freeListRam.sv
specFreeList.sv
renameFreeListTop.sv
tbRenameFreeList.sv

// ==== Makefile ====
# Verilator build and run for the rename free list testbench.

SIM      := verilator
FLAGS    := --binary --timing
TOP      := tbRenameFreeList
FILELIST := filelist.f
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes.
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
